// ==== flist.f ====
common/cache_pkg.sv
cache/cache_way.sv
cache/cache_ctrl.sv
rtl/main_mem.sv
rtl/cache_sys_top.sv
testbench/cache_sys_checker.sv
testbench/cache_sys_tb.sv

// ==== Makefile ====
VERILATOR := verilator
TOP       := cache_sys_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal --timescale 1ns/100ps
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell cat $(FLIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q '\*\*\* PASSED \*\*\*' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== testbench/cache_sys_tb.sv ====
module cache_sys_tb import cache_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int n_directed     = 9;
    localparam int n_random       = 300;
    localparam int timeout_cycles = 12 * (n_directed + n_random) + 100;

    logic      clk;
    logic      rst_n;
    cpu_req_t  req;
    cpu_resp_t resp;

    // architectural view of memory, holding the last value written to each word.
    logic [word_w-1:0] shadow_mem [2**(word_w-1)];
    logic [tag_w-1:0]  ref_tag    [2][2**index_w];
    logic              ref_valid  [2][2**index_w];
    logic              ref_dirty  [2][2**index_w];
    logic              ref_lru    [2**index_w]; // set when way 1 was used last.

    cpu_resp_t exp_q[$];
    int        lat_q[$];
    int        strobe_q[$];
    logic      data_chk_q[$];

    int cycle_cnt      = 0;
    int err_cnt        = 0;
    int n_sent         = 0;
    int n_checked      = 0;
    int n_tests        = 0;
    int n_failed_tests = 0;

    cache_sys_top i_cache_sys_top (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .resp  (resp)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    function automatic void init_model();
        for (int i = 0; i < 2**(word_w-1); i++) begin
            shadow_mem[i] = '0;
        end
        for (int s = 0; s < 2**index_w; s++) begin
            ref_lru[s] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                ref_tag[w][s]   = '0;
                ref_valid[w][s] = 1'b0;
                ref_dirty[w][s] = 1'b0;
            end
        end
    endfunction

    function automatic cache_addr_t make_addr(input int tag, input int set, input int word);
        cache_addr_t a;
        a.fields.tag    = tag_w'(tag);
        a.fields.index  = index_w'(set);
        a.fields.offset = offset_w'(word * 2);
        return a;
    endfunction

    function automatic void predict_access(input cpu_req_t r, output cpu_resp_t exp_resp,
                                           output int exp_lat);
        logic [tag_w-1:0]   t;
        logic [index_w-1:0] s;
        logic [word_w-2:0]  w;
        logic               hit;
        int                 way;
        t   = r.addr.fields.tag;
        s   = r.addr.fields.index;
        w   = r.addr.raw[word_w-1:1];
        hit = 1'b0;
        way = 0;
        if (ref_valid[0][s] && ref_tag[0][s] == t) begin
            hit = 1'b1;
        end else if (ref_valid[1][s] && ref_tag[1][s] == t) begin
            hit = 1'b1;
            way = 1;
        end else if (!ref_valid[0][s]) begin
            way = 0;
        end else if (!ref_valid[1][s]) begin
            way = 1;
        end else begin
            way = ref_lru[s] ? 0 : 1; // replace the older way.
        end
        if (hit)
            exp_lat = 2;
        else if (ref_valid[way][s] && ref_dirty[way][s])
            exp_lat = 11;
        else
            exp_lat = 7;
        if (!hit) begin
            ref_tag[way][s]   = t;
            ref_valid[way][s] = 1'b1;
            ref_dirty[way][s] = 1'b0;
        end
        if (r.wr) begin
            shadow_mem[w]     = r.wdata;
            ref_dirty[way][s] = 1'b1;
        end
        ref_lru[s]     = (way == 1);
        exp_resp       = '0;
        exp_resp.done  = 1'b1;
        exp_resp.hit   = hit;
        exp_resp.rdata = shadow_mem[w];
    endfunction

    task automatic check_resp(input cpu_resp_t got, input cpu_resp_t exp_resp,
                              input logic check_data);
        if (got.stall !== exp_resp.stall) begin
            $display("Mismatch resp.stall: got %h, expected %h", got.stall, exp_resp.stall);
            err_cnt++;
        end
        if (got.hit !== exp_resp.hit) begin
            $display("Mismatch resp.hit: got %h, expected %h", got.hit, exp_resp.hit);
            err_cnt++;
        end
        if (check_data && got.rdata !== exp_resp.rdata) begin
            $display("Mismatch resp.rdata: got %h, expected %h", got.rdata, exp_resp.rdata);
            err_cnt++;
        end
    endtask

    task automatic check_latency(input int got, input int exp_lat);
        if (got != exp_lat) begin
            $display("Mismatch latency: got %h, expected %h", got, exp_lat);
            err_cnt++;
        end
    endtask

    // one strobe per access, then wait until the compare process has seen done.
    task automatic send_access(input logic is_wr, input cache_addr_t addr,
                               input logic [word_w-1:0] data);
        cpu_req_t  r;
        cpu_resp_t exp_resp;
        int        exp_lat;
        r.rd    = ~is_wr;
        r.wr    = is_wr;
        r.addr  = addr;
        r.wdata = is_wr ? data : '0;
        @(negedge clk);
        predict_access(r, exp_resp, exp_lat);
        exp_q.push_back(exp_resp);
        lat_q.push_back(exp_lat);
        strobe_q.push_back(cycle_cnt);
        data_chk_q.push_back(~is_wr);
        req = r;
        n_sent++;
        @(negedge clk);
        // an accepted strobe makes the cache busy in the following cycle.
        if (resp.stall !== 1'b1) begin
            $display("Mismatch resp.stall: got %h, expected %h", resp.stall, 1'b1);
            err_cnt++;
        end
        req = '0;
        wait (n_checked == n_sent);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        n_tests++;
        if (err_cnt == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            n_failed_tests++;
            $display("test %s: %0d errors", name, err_cnt - errs_before);
        end
    endtask

    initial begin : compare_proc
        cpu_resp_t exp_resp;
        int        exp_lat;
        int        strobe_cyc;
        logic      data_chk;
        forever begin
            @(negedge clk);
            if (rst_n && resp.done) begin
                if (exp_q.size() == 0) begin
                    $display("done pulse at %0t with no request outstanding", $time);
                    err_cnt++;
                end else begin
                    exp_resp   = exp_q.pop_front();
                    exp_lat    = lat_q.pop_front();
                    strobe_cyc = strobe_q.pop_front();
                    data_chk   = data_chk_q.pop_front();
                    check_resp(resp, exp_resp, data_chk);
                    check_latency(cycle_cnt - strobe_cyc, exp_lat); // strobe cycle is cycle 0.
                    n_checked++;
                end
            end
        end
    end

    initial begin : watchdog
        wait (cycle_cnt >= timeout_cycles);
        $display("timeout after %0d cycles, an access never completed", cycle_cnt);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin : stimulus
        int errs;
        void'($urandom(32'h5264));
        init_model();
        req   = '0;
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        errs = err_cnt;
        @(negedge clk);
        if (resp.stall !== 1'b0 || resp.done !== 1'b0) begin
            $display("stall or done is high after reset");
            err_cnt++;
        end
        send_access(1'b0, make_addr(7, 200, 1), '0);
        finish_test("reset_state", errs);

        errs = err_cnt;
        send_access(1'b1, make_addr(1, 5, 2), 16'hbeef);
        send_access(1'b0, make_addr(1, 5, 2), '0);
        finish_test("write_then_read", errs);

        errs = err_cnt;
        send_access(1'b1, make_addr(2, 9, 0), 16'h1234);
        send_access(1'b1, make_addr(3, 9, 3), 16'h5678);
        send_access(1'b0, make_addr(2, 9, 0), '0);
        send_access(1'b0, make_addr(3, 9, 3), '0);
        finish_test("two_ways", errs);

        // tag 2 is now the older dirty line in set 9.
        errs = err_cnt;
        send_access(1'b0, make_addr(4, 9, 1), '0);
        send_access(1'b0, make_addr(2, 9, 0), '0);
        finish_test("eviction", errs);

        errs = err_cnt;
        for (int i = 0; i < n_random; i++) begin
            send_access(1'($urandom % 2),
                        make_addr(int'($urandom % 8), int'($urandom % 4), int'($urandom % 4)),
                        16'($urandom));
        end
        finish_test("random_traffic", errs);

        @(negedge clk);
        $display("tests: %0d, failed tests: %0d, errors: %0d", n_tests, n_failed_tests, err_cnt);
        if (err_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== testbench/cache_sys_checker.sv ====
module cache_sys_checker import cache_pkg::*; (
    input logic        clk,
    input logic        rst_n,
    input cpu_resp_t   resp,
    input mem_req_t    mem_req,
    input ctrl_state_t state
);

    timeunit 1ns;
    timeprecision 100ps;

    // done is a single-cycle pulse and never comes while stalled.
    done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        resp.done |-> !resp.stall && !$past(resp.done))
        else $error("done came with stall or stayed high for two cycles");

    // reads and writes never overlap, and the fill reads follow the writeback without a gap.
    mem_one_op: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_req.rd && mem_req.wr) && (!$fell(mem_req.wr) || mem_req.rd))
        else $error("memory read and write overlap, or no read follows a writeback");

    hit_with_done: assert property (@(posedge clk) disable iff (!rst_n)
        resp.hit |-> resp.done && $past(state) == st_comp)
        else $error("hit is high without done or not straight after compare");

    // the busy phase ends only in a state that signals done.
    stall_release: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(resp.stall) |-> resp.done)
        else $error("stall dropped outside a done cycle");

endmodule

bind cache_ctrl cache_sys_checker i_cache_sys_checker (
    .clk     (clk),
    .rst_n   (rst_n),
    .resp    (resp),
    .mem_req (mem_req),
    .state   (state)
);

// ==== rtl/cache_sys_top.sv ====
module cache_sys_top import cache_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  cpu_req_t  req,
    output cpu_resp_t resp
);

    way_cmd_t          cmd0;
    way_cmd_t          cmd1;
    way_stat_t         stat0;
    way_stat_t         stat1;
    mem_req_t          mem_req;
    logic [word_w-1:0] mem_rdata;

    cache_ctrl i_cache_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .resp      (resp),
        .cmd0      (cmd0),
        .cmd1      (cmd1),
        .stat0     (stat0),
        .stat1     (stat1),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata)
    );

    cache_way i_way0 (
        .clk   (clk),
        .rst_n (rst_n),
        .cmd   (cmd0),
        .stat  (stat0)
    );

    cache_way i_way1 (
        .clk   (clk),
        .rst_n (rst_n),
        .cmd   (cmd1),
        .stat  (stat1)
    );

    main_mem i_main_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .mem_req (mem_req),
        .rdata   (mem_rdata)
    );

endmodule

// ==== rtl/main_mem.sv ====
module main_mem import cache_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  mem_req_t          mem_req,
    output logic [word_w-1:0] rdata
);

    logic [word_w-1:0] mem [2**(word_w-1)];
    logic [word_w-1:0] rd_stage;
    logic [word_w-2:0] word_addr;

    assign word_addr = mem_req.addr.raw[word_w-1:1]; // words are 16 bits, bit 0 is unused.

    // the model starts from an all-zero memory.
    initial begin
        for (int i = 0; i < 2**(word_w-1); i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge clk) begin
        if (mem_req.wr)
            mem[word_addr] <= mem_req.wdata;
    end

    // two register stages, so data shows up two cycles after the request.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_stage <= '0;
            rdata    <= '0;
        end else begin
            if (mem_req.rd)
                rd_stage <= mem[word_addr];
            rdata <= rd_stage;
        end
    end

endmodule

// ==== cache/cache_ctrl.sv ====
module cache_ctrl import cache_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_req_t          req,
    output cpu_resp_t         resp,
    output way_cmd_t          cmd0,
    output way_cmd_t          cmd1,
    input  way_stat_t         stat0,
    input  way_stat_t         stat1,
    output mem_req_t          mem_req,
    input  logic [word_w-1:0] mem_rdata
);

    ctrl_state_t           state;
    ctrl_state_t           state_nxt;
    cpu_req_t              req_q;
    logic                  victim_q;
    logic                  victim_sel;
    logic [2**index_w-1:0] lru; // a set bit means way 1 was used last.
    logic [word_w-1:0]     rdata_q;
    way_cmd_t              cmd;
    way_stat_t             sel_stat;
    way_stat_t             vstat;
    logic                  en_both;
    logic                  en_victim;
    logic                  fill_rd;
    logic                  fill_wr;
    logic                  done;
    logic                  stall;
    logic                  accept;
    logic [index_w-1:0]    set_idx;
    logic [1:0]            req_word;
    logic [1:0]            wb_word;
    logic [1:0]            rd_word;
    logic [1:0]            wr_word;

    assign set_idx  = req_q.addr.fields.index;
    assign req_word = req_q.addr.fields.offset[2:1];
    assign wb_word  = 2'(state - st_wb0);
    assign rd_word  = 2'(state - st_fill0);
    assign wr_word  = 2'(state - st_fill2); // way writes trail the memory reads by two cycles.
    assign fill_rd  = state inside {st_fill0, st_fill1, st_fill2, st_fill3};
    assign fill_wr  = state inside {st_fill2, st_fill3, st_fill4, st_fill5};

    assign done   = (state == st_done) || (state == st_fill5);
    assign stall  = (state != st_idle) && !done;
    assign accept = (req.rd | req.wr) & ~stall;

    assign resp.done  = done;
    assign resp.stall = stall;
    assign resp.hit   = (state == st_done); // only a hit ends in the done state.
    // the last line word arrives from memory in the same cycle as done.
    assign resp.rdata = (state == st_fill5 && req_word == 2'd3) ? mem_rdata : rdata_q;

    // hitting way first, then an empty way, then the older one.
    always_comb begin
        if (stat0.hit)
            victim_sel = 1'b0;
        else if (stat1.hit)
            victim_sel = 1'b1;
        else if (!stat0.valid)
            victim_sel = 1'b0;
        else if (!stat1.valid)
            victim_sel = 1'b1;
        else
            victim_sel = ~lru[set_idx];
    end

    assign sel_stat = victim_sel ? stat1 : stat0;
    assign vstat    = victim_q ? stat1 : stat0;

    always_comb begin
        state_nxt  = state;
        cmd        = '0;
        cmd.index  = set_idx;
        cmd.tag    = req_q.addr.fields.tag;
        cmd.offset = req_q.addr.fields.offset;
        cmd.wdata  = req_q.wdata;
        en_both    = 1'b0;
        en_victim  = 1'b0;
        mem_req    = '0;
        case (state)
            st_idle, st_done: begin
                state_nxt = accept ? st_comp : st_idle;
            end
            st_comp: begin
                en_both   = 1'b1;
                cmd.comp  = 1'b1;
                cmd.write = req_q.wr; // a write hit lands here and marks the line dirty.
                if (stat0.hit | stat1.hit)
                    state_nxt = st_done;
                else if (sel_stat.valid & sel_stat.dirty)
                    state_nxt = st_wb0;
                else
                    state_nxt = st_fill0;
            end
            st_wb0, st_wb1, st_wb2, st_wb3: begin
                en_victim                 = 1'b1;
                cmd.offset                = {wb_word, 1'b0};
                mem_req.wr                = 1'b1;
                mem_req.addr.fields.tag    = vstat.tag;
                mem_req.addr.fields.index  = set_idx;
                mem_req.addr.fields.offset = {wb_word, 1'b0};
                mem_req.wdata             = vstat.rdata;
                state_nxt                 = ctrl_state_t'(state + 4'd1);
            end
            st_fill0, st_fill1, st_fill2, st_fill3, st_fill4: begin
                state_nxt = ctrl_state_t'(state + 4'd1);
            end
            st_fill5: begin
                // on a write the last word goes in as a compare write, which sets dirty.
                cmd.comp  = req_q.wr;
                state_nxt = accept ? st_comp : st_idle;
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase

        if (fill_rd) begin
            mem_req.rd                 = 1'b1;
            mem_req.addr.fields.tag    = req_q.addr.fields.tag;
            mem_req.addr.fields.index  = set_idx;
            mem_req.addr.fields.offset = {rd_word, 1'b0};
        end
        if (fill_wr) begin
            en_victim    = 1'b1;
            cmd.write    = 1'b1;
            cmd.valid_in = 1'b1;
            cmd.offset   = {wr_word, 1'b0};
            cmd.wdata    = (req_q.wr && wr_word == req_word) ? req_q.wdata : mem_rdata;
        end

        cmd0        = cmd;
        cmd0.enable = en_both | (en_victim & ~victim_q);
        cmd1        = cmd;
        cmd1.enable = en_both | (en_victim & victim_q);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_idle;
            victim_q <= 1'b0;
            lru      <= '0;
        end else begin
            state <= state_nxt;
            if (state == st_comp)
                victim_q <= victim_sel;
            if (done)
                lru[set_idx] <= victim_q; // the way just used becomes the recent one.
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            req_q <= req;
        if (state == st_comp)
            rdata_q <= sel_stat.rdata;
        else if (fill_wr && wr_word == req_word)
            rdata_q <= mem_rdata;
    end

endmodule

// ==== cache/cache_way.sv ====
module cache_way import cache_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  way_cmd_t  cmd,
    output way_stat_t stat
);

    logic [word_w-1:0]     data_mem [2**index_w][line_words];
    logic [tag_w-1:0]      tag_mem  [2**index_w];
    logic [2**index_w-1:0] valid_bits;
    logic [2**index_w-1:0] dirty_bits;
    logic [1:0]            word_sel;
    logic                  do_write;

    assign word_sel = cmd.offset[2:1]; // byte offset down to a word in the line.

    assign stat.valid = valid_bits[cmd.index];
    assign stat.dirty = dirty_bits[cmd.index];
    assign stat.tag   = tag_mem[cmd.index];
    assign stat.hit   = valid_bits[cmd.index] && (tag_mem[cmd.index] == cmd.tag);
    assign stat.rdata = data_mem[cmd.index][word_sel];

    // a compare write only lands on a hit, a fill write always does.
    assign do_write = cmd.enable & cmd.write & (~cmd.comp | stat.hit);

    always_ff @(posedge clk) begin
        if (do_write) begin
            data_mem[cmd.index][word_sel] <= cmd.wdata;
            if (!cmd.comp)
                tag_mem[cmd.index] <= cmd.tag;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (do_write) begin
            if (cmd.comp) begin
                dirty_bits[cmd.index] <= 1'b1;
            end else begin
                valid_bits[cmd.index] <= cmd.valid_in;
                dirty_bits[cmd.index] <= 1'b0; // freshly filled words match memory.
            end
        end
    end

endmodule

// ==== common/cache_pkg.sv ====
package cache_pkg;

    localparam int tag_w      = 5;
    localparam int index_w    = 8;
    localparam int offset_w   = 3;
    localparam int word_w     = 16;
    localparam int line_words = 4;

    typedef struct packed {
        logic [tag_w-1:0]    tag;
        logic [index_w-1:0]  index;
        logic [offset_w-1:0] offset;
    } addr_fields_t;

    // the same address word, seen whole by memory or split by the cache.
    typedef union packed {
        logic [tag_w+index_w+offset_w-1:0] raw;
        addr_fields_t                      fields;
    } cache_addr_t;

    typedef struct packed {
        logic              rd;
        logic              wr;
        cache_addr_t       addr;
        logic [word_w-1:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic              done;
        logic              stall;
        logic              hit;
        logic [word_w-1:0] rdata;
    } cpu_resp_t;

    typedef struct packed {
        logic              rd;
        logic              wr;
        cache_addr_t       addr;
        logic [word_w-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic                enable;
        logic                comp;
        logic                write;
        logic                valid_in;
        logic [index_w-1:0]  index;
        logic [offset_w-1:0] offset;
        logic [tag_w-1:0]    tag;
        logic [word_w-1:0]   wdata;
    } way_cmd_t;

    typedef struct packed {
        logic              hit;
        logic              dirty;
        logic              valid;
        logic [tag_w-1:0]  tag;
        logic [word_w-1:0] rdata;
    } way_stat_t;

    typedef enum logic [3:0] {
        st_idle,
        st_comp,
        st_wb0,
        st_wb1,
        st_wb2,
        st_wb3,
        st_fill0,
        st_fill1,
        st_fill2,
        st_fill3,
        st_fill4,
        st_fill5,
        st_done
    } ctrl_state_t;

endpackage
